//--- sim.f
+incdir+src
src/rx_dma_pkg.sv
src/fl_frame_receiver.sv
src/rx_frame_buffer.sv
src/rx_dma_engine.sv
src/rx_dma_apb_regs.sv
src/rx_dma_top.sv
testbench/rx_dma_tb.sv

//--- Makefile
# Verilator build and run of the receive DMA testbench

TOP := rx_dma_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/100ps -f sim.f --top-module $(TOP) -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- testbench/rx_dma_tb.sv
// ----------------------------------------------------------------------
// Receive DMA testbench
// Drives frames over the link, models descriptor, DMA and status
// hosts, and checks writes, status words and registers against a
// reference model of the frames
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "rx_dma_settings.svh"

module rx_dma_tb;

  localparam int NFRAMES = 12;
  localparam int MAX_WORDS = 40;

  logic clk = 1'b0;
  logic rst;
  rx_dma_pkg::fl_beat_t   rx_beat;
  logic                   rx_src_rdy;
  logic                   rx_dst_rdy;
  logic                   desc_read;
  logic [31:0]            desc_addr = 32'd0;
  logic                   desc_vld = 1'b0;
  logic                   desc_empty = 1'b1;
  logic                   dma_req;
  rx_dma_pkg::dma_wr_t    dma_wr;
  logic                   dma_ack = 1'b0;
  logic                   su_vld;
  rx_dma_pkg::rx_status_t su_data;
  logic                   su_hfull = 1'b0;
  rx_dma_pkg::apb_req_t   apb_req;
  rx_dma_pkg::apb_rsp_t   apb_rsp;

  // Frame contents and descriptor list
  int          nwords [NFRAMES];
  int          start [NFRAMES];
  logic [1:0]  rem_v [NFRAMES];
  logic [31:0] desc_list [NFRAMES];
  logic [31:0] data_mem [NFRAMES*MAX_WORDS];
  int          total_words = 0;
  int          limit_cycles = 0;

  // Progress seen by the monitor
  int   words_in = 0;
  int   frames_in = 0;
  int   frames_out = 0;
  int   word_out = 0;
  int   desc_idx = 0;
  logic desc_asked = 1'b0;
  logic held_valid = 1'b0;
  rx_dma_pkg::dma_wr_t held_wr;
  logic tb_run = 1'b0;
  logic link_go = 1'b0;

  rx_dma_top rx_dma_top_inst (
    .clk        (clk),
    .rst        (rst),
    .rx_beat    (rx_beat),
    .rx_src_rdy (rx_src_rdy),
    .rx_dst_rdy (rx_dst_rdy),
    .desc_read  (desc_read),
    .desc_addr  (desc_addr),
    .desc_vld   (desc_vld),
    .desc_empty (desc_empty),
    .dma_req    (dma_req),
    .dma_wr     (dma_wr),
    .dma_ack    (dma_ack),
    .su_vld     (su_vld),
    .su_data    (su_data),
    .su_hfull   (su_hfull),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp)
  );

  // 20 ns clock
  always #10 clk = ~clk;

  // ----------------------------------------------------------------------
  // Reference model and checks
  // ----------------------------------------------------------------------
  // Word i of frame k lands at descriptor k plus 4*i
  function automatic rx_dma_pkg::dma_wr_t expected_write(input int k, input int i);
    rx_dma_pkg::dma_wr_t w;
    w.addr = desc_list[k] + 32'(4 * i);
    w.data = data_mem[start[k] + i];
    return w;
  endfunction

  // Length from beat count and rem, sequence from frame order
  function automatic rx_dma_pkg::rx_status_t expected_status(input int k);
    rx_dma_pkg::rx_status_t s;
    s.seq = 16'(k);
    s.len = 16'((nwords[k] - 1) * 4 + int'(rem_v[k]) + 1);
    return s;
  endfunction

  function automatic rx_dma_pkg::apb_rsp_t apb_expect(input logic [31:0] data,
                                                       input logic err);
    rx_dma_pkg::apb_rsp_t r;
    r.prdata  = data;
    r.pready  = 1'b1;
    r.pslverr = err;
    return r;
  endfunction

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_dma(input rx_dma_pkg::dma_wr_t got, input rx_dma_pkg::dma_wr_t exp,
                           input string name);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_with_error("DMA write differs from the reference");
    end
  endtask

  task automatic check_status(input rx_dma_pkg::rx_status_t got,
                              input rx_dma_pkg::rx_status_t exp, input string name);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_with_error("Status word differs from the reference");
    end
  endtask

  task automatic check_apb(input rx_dma_pkg::apb_rsp_t got, input rx_dma_pkg::apb_rsp_t exp,
                           input string name);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_with_error("APB response differs from the expected value");
    end
  endtask

  // Setup then access phase
  // Response sampled mid access
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output rx_dma_pkg::apb_rsp_t rsp);
    @(posedge clk);
    #2;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clk);
    #2;
    apb_req.penable = 1'b1;
    @(negedge clk);
    rsp = apb_rsp;
    @(posedge clk);
    #2;
    apb_req = '0;
  endtask

  task automatic read_and_check(input logic [7:0] addr, input rx_dma_pkg::apb_rsp_t exp,
                                input string name);
    rx_dma_pkg::apb_rsp_t rsp;
    apb_access(1'b0, addr, 32'd0, rsp);
    check_apb(rsp, exp, name);
  endtask

  // ----------------------------------------------------------------------
  // Host models driven 2 ns after the edge
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    #2;
    // Descriptor answers one cycle after the read
    desc_vld = desc_asked;
    if (desc_asked) begin
      desc_addr = desc_list[desc_idx];
      desc_idx  = desc_idx + 1;
    end
    desc_empty = (desc_idx >= NFRAMES) || ($urandom % 5 == 0);
    dma_ack    = ($urandom % 3) != 0;
    su_hfull   = ($urandom % 4) == 0;
  end

  // Monitor and compare at the falling edge where outputs are settled
  always @(negedge clk) begin
    if (rst) begin
      desc_asked = 1'b0;
    end else begin
      desc_asked = desc_read;
      if (rx_src_rdy && rx_dst_rdy) begin
        words_in = words_in + 1;
        if (rx_beat.eof) frames_in = frames_in + 1;
      end
      if (!tb_run && (desc_read || dma_req))
        stop_with_error("Engine started a transfer while run was 0");
      if (desc_read && desc_empty)
        stop_with_error("Descriptor read while the descriptor queue was empty");
      if (su_vld && su_hfull)
        stop_with_error("Status pulse while the status queue was half full");
      if (dma_req) begin
        if (held_valid) check_dma(dma_wr, held_wr, "dma_wr held");
        if (dma_ack) begin
          if (frames_out >= NFRAMES || word_out >= nwords[frames_out])
            stop_with_error("DMA write beyond the end of the frame");
          check_dma(dma_wr, expected_write(frames_out, word_out), "dma_wr");
          word_out   = word_out + 1;
          held_valid = 1'b0;
        end else begin
          held_valid = 1'b1;
          held_wr    = dma_wr;
        end
      end
      if (su_vld) begin
        if (frames_out >= NFRAMES || word_out != nwords[frames_out])
          stop_with_error("Status sent before all words of the frame were written");
        check_status(su_data, expected_status(frames_out), "su_data");
        frames_out = frames_out + 1;
        word_out   = 0;
      end
    end
  end

  // Link source with random idle gaps between beats
  initial begin : link_source
    int   k;
    int   i;
    logic taken;
    rx_beat    = '0;
    rx_src_rdy = 1'b0;
    wait (link_go);
    @(posedge clk);
    #2;
    for (k = 0; k < NFRAMES; k++) begin
      for (i = 0; i < nwords[k]; i++) begin
        if ($urandom % 8 == 0) begin
          rx_src_rdy = 1'b0;
          @(posedge clk);
          #2;
        end
        rx_beat.data = data_mem[start[k] + i];
        rx_beat.sof  = i == 0;
        rx_beat.eof  = i == nwords[k] - 1;
        rx_beat.rem  = rx_beat.eof ? rem_v[k] : 2'd0;
        rx_src_rdy   = 1'b1;
        // Hold the beat until it is taken
        taken = 1'b0;
        while (!taken) begin
          @(negedge clk);
          taken = rx_dst_rdy;
          @(posedge clk);
          #2;
        end
      end
    end
    rx_src_rdy = 1'b0;
  end

  // Limit scales with the words to move
  initial begin : watchdog
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    stop_with_error("Timeout: the frames did not drain in the expected time");
  end

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin : main_sequence
    rx_dma_pkg::apb_rsp_t rsp;
    int k;
    int i;
    apb_req = '0;
    rst     = 1'b1;
    void'($urandom(86));
    for (k = 0; k < NFRAMES; k++) begin
      nwords[k]    = 1 + int'($urandom % MAX_WORDS);
      rem_v[k]     = 2'($urandom % 4);
      start[k]     = total_words;
      desc_list[k] = $urandom & 32'hFFFF_FFFC;
      for (i = 0; i < nwords[k]; i++) data_mem[total_words + i] = $urandom;
      total_words = total_words + nwords[k];
    end
    limit_cycles = 4 * total_words + 40 * NFRAMES + 600;
    repeat (16) @(posedge clk);
    #2;
    rst = 1'b0;

    // Register defaults, run write and read back, bad offset
    read_and_check(`RX_REG_CTRL, apb_expect(32'd0, 1'b0), "CTRL");
    read_and_check(`RX_REG_STATUS, apb_expect(32'd1, 1'b0), "STATUS");
    read_and_check(`RX_REG_FRAMES, apb_expect(32'd0, 1'b0), "FRAMES");
    apb_access(1'b1, `RX_REG_CTRL, 32'd1, rsp);
    read_and_check(`RX_REG_CTRL, apb_expect(32'd1, 1'b0), "CTRL");
    apb_access(1'b1, `RX_REG_CTRL, 32'd0, rsp);
    read_and_check(`RX_REG_CTRL, apb_expect(32'd0, 1'b0), "CTRL");
    read_and_check(8'h0C, apb_expect(32'd0, 1'b1), "unmapped");

    // Fill while stopped until the link stalls
    link_go = 1'b1;
    @(negedge clk);
    while (!(rx_src_rdy && !rx_dst_rdy)) @(negedge clk);
    if (!(words_in == `RX_BUF_WORDS || frames_in == `RX_FRAME_SLOTS))
      stop_with_error("Link stalled before the buffer was full");
    repeat (20) begin
      @(negedge clk);
      if (rx_dst_rdy) stop_with_error("Link resumed while the engine was stopped");
    end

    // Start the engine and drain everything
    apb_access(1'b1, `RX_REG_CTRL, 32'd1, rsp);
    tb_run = 1'b1;
    wait (frames_out == NFRAMES);
    repeat (4) @(posedge clk);
    // Empty buffer has room again
    if (!rx_dst_rdy) stop_with_error("Link not ready after the buffer drained");
    read_and_check(`RX_REG_STATUS, apb_expect(32'd1, 1'b0), "STATUS");
    read_and_check(`RX_REG_FRAMES, apb_expect(32'(NFRAMES), 1'b0), "FRAMES");
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- src/rx_dma_top.sv
// ----------------------------------------------------------------------
// Receive DMA top level
// Link receiver, frame buffer, DMA engine and APB registers
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "rx_dma_settings.svh"

module rx_dma_top (
  input  logic                   clk,
  input  logic                   rst,
  input  rx_dma_pkg::fl_beat_t   rx_beat,
  input  logic                   rx_src_rdy,
  output logic                   rx_dst_rdy,
  output logic                   desc_read,
  input  logic [31:0]            desc_addr,
  input  logic                   desc_vld,
  input  logic                   desc_empty,
  output logic                   dma_req,
  output rx_dma_pkg::dma_wr_t    dma_wr,
  input  logic                   dma_ack,
  output logic                   su_vld,
  output rx_dma_pkg::rx_status_t su_data,
  input  logic                   su_hfull,
  input  rx_dma_pkg::apb_req_t   apb_req,
  output rx_dma_pkg::apb_rsp_t   apb_rsp
);

  // Receiver to buffer
  logic                   words_free_ok;
  logic                   slot_free_ok;
  logic                   wr_en;
  logic [`RX_DATA_W-1:0]  wr_word;
  logic                   rec_push;
  rx_dma_pkg::frame_rec_t rec;

  // Buffer to engine
  logic                   frame_avail;
  logic [`RX_DATA_W-1:0]  head_word;
  rx_dma_pkg::frame_rec_t head_rec;
  logic                   word_pop;
  logic                   rec_pop;

  // Engine and registers
  logic                   run;
  logic                   busy;
  logic                   sent_pulse;

  fl_frame_receiver fl_frame_receiver_inst (
    .clk           (clk),
    .rst           (rst),
    .rx_beat       (rx_beat),
    .rx_src_rdy    (rx_src_rdy),
    .rx_dst_rdy    (rx_dst_rdy),
    .words_free_ok (words_free_ok),
    .slot_free_ok  (slot_free_ok),
    .wr_en         (wr_en),
    .wr_word       (wr_word),
    .rec_push      (rec_push),
    .rec           (rec)
  );

  rx_frame_buffer rx_frame_buffer_inst (
    .clk           (clk),
    .rst           (rst),
    .wr_en         (wr_en),
    .wr_word       (wr_word),
    .rec_push      (rec_push),
    .rec           (rec),
    .words_free_ok (words_free_ok),
    .slot_free_ok  (slot_free_ok),
    .word_pop      (word_pop),
    .rec_pop       (rec_pop),
    .frame_avail   (frame_avail),
    .head_word     (head_word),
    .head_rec      (head_rec)
  );

  rx_dma_engine rx_dma_engine_inst (
    .clk         (clk),
    .rst         (rst),
    .run         (run),
    .frame_avail (frame_avail),
    .head_word   (head_word),
    .head_rec    (head_rec),
    .word_pop    (word_pop),
    .rec_pop     (rec_pop),
    .desc_read   (desc_read),
    .desc_addr   (desc_addr),
    .desc_vld    (desc_vld),
    .desc_empty  (desc_empty),
    .dma_req     (dma_req),
    .dma_wr      (dma_wr),
    .dma_ack     (dma_ack),
    .su_vld      (su_vld),
    .su_data     (su_data),
    .su_hfull    (su_hfull),
    .busy        (busy),
    .sent_pulse  (sent_pulse)
  );

  rx_dma_apb_regs rx_dma_apb_regs_inst (
    .clk         (clk),
    .rst         (rst),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .busy        (busy),
    .frame_avail (frame_avail),
    .sent_pulse  (sent_pulse),
    .run         (run)
  );

endmodule

//--- src/rx_dma_apb_regs.sv
// ----------------------------------------------------------------------
// Receive DMA control registers
// APB slave with run control, idle status and a sent-frame counter
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "rx_dma_settings.svh"

module rx_dma_apb_regs (
  input  logic                 clk,
  input  logic                 rst,
  input  rx_dma_pkg::apb_req_t apb_req,
  output rx_dma_pkg::apb_rsp_t apb_rsp,
  input  logic                 busy,
  input  logic                 frame_avail,
  input  logic                 sent_pulse,
  output logic                 run
);

  logic        access;
  logic        hit_ctrl;
  logic        hit_status;
  logic        hit_frames;
  logic        idle;
  logic [31:0] frame_cnt;

  // Access phase of a zero-wait transfer
  assign access = apb_req.psel && apb_req.penable;

  // Offset decode
  assign hit_ctrl   = apb_req.paddr == `RX_REG_CTRL;
  assign hit_status = apb_req.paddr == `RX_REG_STATUS;
  assign hit_frames = apb_req.paddr == `RX_REG_FRAMES;

  // Engine parked and nothing stored
  assign idle = !busy && !frame_avail;

  // ----------------------------------------------------------------------
  // Read data and response
  // ----------------------------------------------------------------------
  always_comb begin
    apb_rsp.prdata  = '0;
    apb_rsp.pready  = 1'b1;
    apb_rsp.pslverr = access && !(hit_ctrl || hit_status || hit_frames);
    if (access) begin
      if (hit_ctrl) apb_rsp.prdata = {31'd0, run};
      if (hit_status) apb_rsp.prdata = {31'd0, idle};
      if (hit_frames) apb_rsp.prdata = frame_cnt;
    end
  end

  // Only the run bit takes writes
  always_ff @(posedge clk) begin
    if (rst) begin
      run <= 1'b0;
    end else if (access && apb_req.pwrite && hit_ctrl) begin
      run <= apb_req.pwdata[0];
    end
  end

  // Status words sent
  always_ff @(posedge clk) begin
    if (rst) begin
      frame_cnt <= '0;
    end else if (sent_pulse) begin
      frame_cnt <= frame_cnt + 32'd1;
    end
  end

endmodule

//--- src/rx_dma_engine.sv
// ----------------------------------------------------------------------
// Receive DMA engine
// Per stored frame: fetch a host descriptor, write the frame word by
// word to host memory, then report length and sequence number
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "rx_dma_settings.svh"

module rx_dma_engine (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   run,
  input  logic                   frame_avail,
  input  logic [`RX_DATA_W-1:0]  head_word,
  input  rx_dma_pkg::frame_rec_t head_rec,
  output logic                   word_pop,
  output logic                   rec_pop,
  output logic                   desc_read,
  input  logic [31:0]            desc_addr,
  input  logic                   desc_vld,
  input  logic                   desc_empty,
  output logic                   dma_req,
  output rx_dma_pkg::dma_wr_t    dma_wr,
  input  logic                   dma_ack,
  output logic                   su_vld,
  output rx_dma_pkg::rx_status_t su_data,
  input  logic                   su_hfull,
  output logic                   busy,
  output logic                   sent_pulse
);

  // FSM encoding
  localparam logic [1:0] S_WAIT   = 2'd0;
  localparam logic [1:0] S_DESC   = 2'd1;
  localparam logic [1:0] S_WRITE  = 2'd2;
  localparam logic [1:0] S_STATUS = 2'd3;

  logic [1:0]           state;
  logic [31:0]          host_addr;
  logic [`RX_LEN_W-1:0] words_left;
  logic [`RX_LEN_W-1:0] len_q;
  logic [15:0]          seq_q;

  // ----------------------------------------------------------------------
  // Strobes decoded from state and handshake inputs
  // ----------------------------------------------------------------------
  // Fetch only with run set, a frame stored and a descriptor ready
  assign desc_read = (state == S_WAIT) && run && frame_avail && !desc_empty;

  // Write request held until acked
  assign dma_req  = state == S_WRITE;
  assign word_pop = dma_req && dma_ack;

  // Status waits for room in the status FIFO
  assign su_vld     = (state == S_STATUS) && !su_hfull;
  assign rec_pop    = su_vld;
  assign sent_pulse = su_vld;

  assign busy = state != S_WAIT;

  always_comb begin
    dma_wr.addr  = host_addr;
    dma_wr.data  = head_word;
    su_data.seq  = seq_q;
    su_data.len  = len_q;
  end

  // Control path
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_WAIT;
      seq_q <= '0;
    end else begin
      case (state)
        S_WAIT: begin
          if (desc_read) state <= S_DESC;
        end
        // Descriptor returns one cycle after the read
        S_DESC: begin
          if (desc_vld) state <= S_WRITE;
        end
        S_WRITE: begin
          // Last word acked
          if (word_pop && words_left == `RX_LEN_W'd1) state <= S_STATUS;
        end
        default: begin
          if (su_vld) begin
            state <= S_WAIT;
            seq_q <= seq_q + 1'b1;
          end
        end
      endcase
    end
  end

  // Per-frame address and word count
  always_ff @(posedge clk) begin
    if (state == S_DESC && desc_vld) begin
      host_addr  <= desc_addr;
      len_q      <= head_rec.len;
      // Byte length rounded up to whole words
      words_left <= (head_rec.len + `RX_LEN_W'd3) >> 2;
    end else if (word_pop) begin
      host_addr  <= host_addr + 32'd4;
      words_left <= words_left - 1'b1;
    end
  end

endmodule

//--- src/rx_frame_buffer.sv
// ----------------------------------------------------------------------
// Receive frame buffer
// Circular data word memory plus a small queue of frame length
// records, with occupancy counts for flow control
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "rx_dma_settings.svh"

module rx_frame_buffer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   wr_en,
  input  logic [`RX_DATA_W-1:0]  wr_word,
  input  logic                   rec_push,
  input  rx_dma_pkg::frame_rec_t rec,
  output logic                   words_free_ok,
  output logic                   slot_free_ok,
  input  logic                   word_pop,
  input  logic                   rec_pop,
  output logic                   frame_avail,
  output logic [`RX_DATA_W-1:0]  head_word,
  output rx_dma_pkg::frame_rec_t head_rec
);

  localparam int WORD_AW = $clog2(`RX_BUF_WORDS);
  localparam int SLOT_AW = $clog2(`RX_FRAME_SLOTS);

  // Storage
  logic [`RX_DATA_W-1:0]  word_mem [`RX_BUF_WORDS];
  rx_dma_pkg::frame_rec_t rec_mem  [`RX_FRAME_SLOTS];

  // Word queue pointers and fill
  logic [WORD_AW-1:0] word_wr_ptr;
  logic [WORD_AW-1:0] word_rd_ptr;
  logic [WORD_AW:0]   word_cnt;

  // Record queue pointers and fill
  logic [SLOT_AW-1:0] rec_wr_ptr;
  logic [SLOT_AW-1:0] rec_rd_ptr;
  logic [SLOT_AW:0]   rec_cnt;

  // ----------------------------------------------------------------------
  // Status towards receiver and engine
  // ----------------------------------------------------------------------
  assign words_free_ok = word_cnt < (WORD_AW+1)'(`RX_BUF_WORDS);
  assign slot_free_ok  = rec_cnt < (SLOT_AW+1)'(`RX_FRAME_SLOTS);
  assign frame_avail   = rec_cnt != '0;

  // Heads of both queues read asynchronously
  assign head_word = word_mem[word_rd_ptr];
  assign head_rec  = rec_mem[rec_rd_ptr];

  // Memory writes
  always_ff @(posedge clk) begin
    if (wr_en) begin
      word_mem[word_wr_ptr] <= wr_word;
    end
    if (rec_push) begin
      rec_mem[rec_wr_ptr] <= rec;
    end
  end

  // Word pointers wrap on power-of-two depth
  always_ff @(posedge clk) begin
    if (rst) begin
      word_wr_ptr <= '0;
      word_rd_ptr <= '0;
      word_cnt    <= '0;
    end else begin
      if (wr_en) word_wr_ptr <= word_wr_ptr + 1'b1;
      if (word_pop) word_rd_ptr <= word_rd_ptr + 1'b1;
      // Push and pop together leave the fill unchanged
      case ({wr_en, word_pop})
        2'b10:   word_cnt <= word_cnt + 1'b1;
        2'b01:   word_cnt <= word_cnt - 1'b1;
        default: word_cnt <= word_cnt;
      endcase
    end
  end

  // Record pointers
  always_ff @(posedge clk) begin
    if (rst) begin
      rec_wr_ptr <= '0;
      rec_rd_ptr <= '0;
      rec_cnt    <= '0;
    end else begin
      if (rec_push) rec_wr_ptr <= rec_wr_ptr + 1'b1;
      if (rec_pop) rec_rd_ptr <= rec_rd_ptr + 1'b1;
      case ({rec_push, rec_pop})
        2'b10:   rec_cnt <= rec_cnt + 1'b1;
        2'b01:   rec_cnt <= rec_cnt - 1'b1;
        default: rec_cnt <= rec_cnt;
      endcase
    end
  end

endmodule

//--- src/fl_frame_receiver.sv
// ----------------------------------------------------------------------
// FrameLink frame receiver
// Accepts link beats, writes data words into the frame buffer and
// pushes a length record on the last beat of each frame
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "rx_dma_settings.svh"

module fl_frame_receiver (
  input  logic                  clk,
  input  logic                  rst,
  input  rx_dma_pkg::fl_beat_t  rx_beat,
  input  logic                  rx_src_rdy,
  output logic                  rx_dst_rdy,
  input  logic                  words_free_ok,
  input  logic                  slot_free_ok,
  output logic                  wr_en,
  output logic [`RX_DATA_W-1:0] wr_word,
  output logic                  rec_push,
  output rx_dma_pkg::frame_rec_t rec
);

  // Beats already taken in the current frame
  logic [`RX_LEN_W-3:0] beat_cnt;
  logic [`RX_LEN_W-3:0] beats_so_far;
  logic                 accept;
  logic [`RX_LEN_W-1:0] len_bytes;

  // Room for one more word and one more frame record
  assign rx_dst_rdy = words_free_ok && slot_free_ok;

  // Beat transfer when both sides ready
  assign accept = rx_src_rdy && rx_dst_rdy;

  // SOF restarts the count even if a frame was cut short
  assign beats_so_far = rx_beat.sof ? '0 : beat_cnt;

  // (beats - 1) * 4 + rem + 1
  assign len_bytes = {beats_so_far, 2'b00}
                   + {{(`RX_LEN_W-`RX_REM_W){1'b0}}, rx_beat.rem}
                   + `RX_LEN_W'd1;

  // ----------------------------------------------------------------------
  // Buffer write side
  // ----------------------------------------------------------------------
  assign wr_en    = accept;
  assign wr_word  = rx_beat.data;

  // Record goes in with the last word
  assign rec_push = accept && rx_beat.eof;
  assign rec.len  = len_bytes;

  // Beat counter
  always_ff @(posedge clk) begin
    if (rst) begin
      beat_cnt <= '0;
    end else if (accept) begin
      if (rx_beat.eof) begin
        beat_cnt <= '0;
      end else begin
        beat_cnt <= beats_so_far + 1'b1;
      end
    end
  end

endmodule

//--- src/rx_dma_pkg.sv
// ----------------------------------------------------------------------
// Receive DMA package
// Packed struct types for the link, buffer, DMA, status and APB ports
// ----------------------------------------------------------------------
`include "rx_dma_settings.svh"

package rx_dma_pkg;

  // One FrameLink beat
  // Rem holds valid bytes minus one on the EOF beat
  typedef struct packed {
    logic [`RX_DATA_W-1:0] data;
    logic [`RX_REM_W-1:0]  rem;
    logic                  sof;
    logic                  eof;
  } fl_beat_t;

  // Record of one stored frame
  typedef struct packed {
    logic [`RX_LEN_W-1:0] len;
  } frame_rec_t;

  // Single DMA write to host memory
  typedef struct packed {
    logic [31:0]           addr;
    logic [`RX_DATA_W-1:0] data;
  } dma_wr_t;

  // Status word reported per frame
  typedef struct packed {
    logic [15:0]          seq;
    logic [`RX_LEN_W-1:0] len;
  } rx_status_t;

  // APB request from the master
  typedef struct packed {
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [`RX_APB_ADDR_W-1:0] paddr;
    logic [31:0]              pwdata;
  } apb_req_t;

  // APB response
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

endpackage

//--- src/rx_dma_settings.svh
// ----------------------------------------------------------------------
// Receive DMA settings
// Widths, buffer depths and APB register offsets shared by all blocks
// ----------------------------------------------------------------------
`ifndef RX_DMA_SETTINGS_SVH
`define RX_DMA_SETTINGS_SVH

// Link data word and valid-byte index
`define RX_DATA_W 32
`define RX_REM_W 2

// On-chip buffer sizing
`define RX_BUF_WORDS 64
`define RX_FRAME_SLOTS 4

// Frame byte length
`define RX_LEN_W 16

// APB register map
`define RX_APB_ADDR_W 8
`define RX_REG_CTRL 8'h00
`define RX_REG_STATUS 8'h04
`define RX_REG_FRAMES 8'h08

`endif
